/* frontend_pkg.sv */
`default_nettype none

package frontend_pkg;

    // fetch geometry
    localparam int XLEN        = 32;
    localparam int FETCH_WIDTH = 2;
    localparam int FIFO_DEPTH  = 8;

    localparam logic [XLEN-1:0] RESET_PC = 32'h1c00_0000;

    // axi4-lite encodings seen on the fetch path
    // prot: unprivileged, secure, instruction access
    localparam logic [2:0] AXI_PROT_INST = 3'b100;
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    // substituted for a word that came back with an error response
    localparam logic [XLEN-1:0] INST_NOP = 32'h0340_0000;

    // register usage class of one instruction
    typedef enum logic [2:0] {
        REG_RW,
        REG_RRW,
        REG_I,
        REG_BL,
        REG_RR,
        REG_W
    } reg_type_e;

    // major opcode is bits 31..26 of the word
    function automatic reg_type_e classify_opcode(input logic [5:0] opcode);
        reg_type_e ret;
        if (opcode == 6'b000101) begin
            // lu12i class sits inside the rw range
            ret = REG_W;
        end else if (opcode == 6'b000000) begin
            ret = REG_RRW;
        end else if (opcode <= 6'b001111) begin
            ret = REG_RW;
        end else if (opcode == 6'b010100) begin
            ret = REG_I;
        end else if (opcode == 6'b010101) begin
            ret = REG_BL;
        end else if (opcode >= 6'b010110 && opcode <= 6'b011011) begin
            // conditional branches read two registers
            ret = REG_RR;
        end else begin
            ret = REG_I;
        end
        return ret;
    endfunction

    // one buffered instruction
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] word;
        logic [4:0]      rj;
        logic [4:0]      rk;
        logic [4:0]      rd;
    } fetch_entry_t;

endpackage

`default_nettype wire

/* npc.sv */
`timescale 1ns/1ps
`default_nettype none

module npc (
    input  wire logic                          clk,
    input  wire logic                          rst_n_i,

    // redirect from the backend
    input  wire logic                          flush_i,
    input  wire logic [frontend_pkg::XLEN-1:0] redirect_pc_i,

    // packet address handshake with the fetch unit
    input  wire logic                          pc_ready_i,
    output logic      [frontend_pkg::XLEN-1:0] pc_o
);

    logic [frontend_pkg::XLEN-1:0] pc_next;
    logic [frontend_pkg::XLEN-1:3] pc_seq;

    // next aligned packet, static fall-through
    assign pc_seq = pc_o[frontend_pkg::XLEN-1:3] + 1'b1;

    always_comb begin
        pc_next = pc_o;
        if (flush_i) begin
            // keep bit 2 so a target at offset 4 starts in lane 1
            pc_next = {redirect_pc_i[frontend_pkg::XLEN-1:2], 2'b00};
        end else if (pc_ready_i) begin
            pc_next = {pc_seq, 3'b000};
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_o <= frontend_pkg::RESET_PC;
        end else begin
            pc_o <= pc_next;
        end
    end

endmodule

`default_nettype wire

/* inst_predecode.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_predecode (
    input  wire logic [frontend_pkg::XLEN-1:0] word_i,
    output logic      [4:0]                    rj_o,
    output logic      [4:0]                    rk_o,
    output logic      [4:0]                    rd_o
);

    frontend_pkg::reg_type_e reg_type;

    assign reg_type = frontend_pkg::classify_opcode(word_i[31:26]);

    always_comb begin
        rj_o = '0;
        rk_o = '0;
        rd_o = '0;
        case (reg_type)
            frontend_pkg::REG_RW: begin
                rj_o = word_i[9:5];
                rd_o = word_i[4:0];
            end
            frontend_pkg::REG_RRW: begin
                rk_o = word_i[14:10];
                rj_o = word_i[9:5];
                rd_o = word_i[4:0];
            end
            frontend_pkg::REG_BL: begin
                // link register is r1
                rd_o = 5'd1;
            end
            frontend_pkg::REG_RR: begin
                // branch compares rd field against rj, nothing written
                rk_o = word_i[4:0];
                rj_o = word_i[9:5];
            end
            frontend_pkg::REG_W: begin
                rd_o = word_i[4:0];
            end
            default: begin
                // REG_I uses no registers
                rj_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  wire logic                                clk,
    input  wire logic                                rst_n_i,
    input  wire logic                                flush_i,

    // packet address from npc
    input  wire logic [frontend_pkg::XLEN-1:0]       pc_i,
    output logic                                     pc_ready_o,

    // axi4-lite read address channel
    output logic      [frontend_pkg::XLEN-1:0]       araddr_o,
    output logic      [2:0]                          arprot_o,
    output logic                                     arvalid_o,
    input  wire logic                                arready_i,

    // axi4-lite read data channel
    input  wire logic [frontend_pkg::XLEN-1:0]       rdata_i,
    input  wire logic [1:0]                          rresp_i,
    input  wire logic                                rvalid_i,
    output logic                                     rready_o,

    // external predecode, one block per slot
    output logic [frontend_pkg::FETCH_WIDTH-1:0][frontend_pkg::XLEN-1:0] pd_word_o,
    input  wire logic [frontend_pkg::FETCH_WIDTH-1:0][4:0] pd_rj_i,
    input  wire logic [frontend_pkg::FETCH_WIDTH-1:0][4:0] pd_rk_i,
    input  wire logic [frontend_pkg::FETCH_WIDTH-1:0][4:0] pd_rd_i,

    // fifo write side
    input  wire logic                                write_ready_i,
    output logic      [1:0]                          write_num_o,
    output frontend_pkg::fetch_entry_t [frontend_pkg::FETCH_WIDTH-1:0] write_data_o
);

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA,
        WRITE
    } state_e;

    state_e state;
    logic   slot;
    logic   kill;
    logic   accept;
    logic   ar_fire;
    logic   r_fire;

    // packet payload
    logic [frontend_pkg::XLEN-1:3] pkt_base;
    logic                          hi_only;
    logic [frontend_pkg::FETCH_WIDTH-1:0][frontend_pkg::XLEN-1:0] words;

    frontend_pkg::fetch_entry_t lane_lo;
    frontend_pkg::fetch_entry_t lane_hi;

    // no new packet while flushing or without room for two entries
    assign accept     = (state == IDLE) && write_ready_i && !flush_i;
    assign pc_ready_o = accept;

    assign arvalid_o = (state == ADDR);
    assign araddr_o  = {pkt_base, slot, 2'b00};
    assign arprot_o  = frontend_pkg::AXI_PROT_INST;
    assign ar_fire   = arvalid_o && arready_i;

    assign rready_o = (state == DATA);
    assign r_fire   = rready_o && rvalid_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state <= IDLE;
            slot  <= 1'b0;
            kill  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        // packet at offset 4 needs only the second slot
                        slot  <= pc_i[2];
                        kill  <= 1'b0;
                        state <= ADDR;
                    end
                end
                ADDR: begin
                    if (flush_i) begin
                        kill <= 1'b1;
                    end
                    if (ar_fire) begin
                        state <= DATA;
                    end
                end
                DATA: begin
                    if (flush_i) begin
                        kill <= 1'b1;
                    end
                    if (r_fire) begin
                        if (kill || flush_i) begin
                            // read finished, packet dropped
                            state <= IDLE;
                        end else if (!slot) begin
                            slot  <= 1'b1;
                            state <= ADDR;
                        end else begin
                            state <= WRITE;
                        end
                    end
                end
                default: begin
                    if (write_ready_i) begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pkt_base <= pc_i[frontend_pkg::XLEN-1:3];
            hi_only  <= pc_i[2];
        end
        if (r_fire) begin
            if (rresp_i == frontend_pkg::AXI_RESP_OKAY) begin
                words[slot] <= rdata_i;
            end else begin
                words[slot] <= frontend_pkg::INST_NOP;
            end
        end
    end

    assign pd_word_o = words;

    always_comb begin
        lane_lo.pc   = {pkt_base, 3'b000};
        lane_lo.word = words[0];
        lane_lo.rj   = pd_rj_i[0];
        lane_lo.rk   = pd_rk_i[0];
        lane_lo.rd   = pd_rd_i[0];

        lane_hi.pc   = {pkt_base, 3'b100};
        lane_hi.word = words[1];
        lane_hi.rj   = pd_rj_i[1];
        lane_hi.rk   = pd_rk_i[1];
        lane_hi.rd   = pd_rd_i[1];
    end

    // lane 0 always carries the older instruction
    assign write_data_o[0] = hi_only ? lane_hi : lane_lo;
    assign write_data_o[1] = lane_hi;

    always_comb begin
        write_num_o = 2'd0;
        if (state == WRITE && write_ready_i) begin
            write_num_o = hi_only ? 2'd1 : 2'd2;
        end
    end

endmodule

`default_nettype wire

/* multi_channel_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module multi_channel_fifo #(
    parameter type T     = logic [31:0],
    parameter int  DEPTH = 8
) (
    input  wire logic       clk,
    input  wire logic       rst_n_i,
    input  wire logic       flush_i,

    // push side, lane 0 is older
    input  wire logic [1:0] write_num_i,
    input  wire T [1:0]     write_data_i,
    output logic            write_ready_o,

    // pop side
    input  wire logic [1:0] read_num_i,
    output logic      [1:0] read_valid_o,
    output T [1:0]          read_data_o
);

    T mem [DEPTH];

    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr_p1;
    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] wr_ptr_p1;
    logic [$clog2(DEPTH):0]   count;

    logic [1:0] push_num;
    logic [1:0] pop_num;

    // depth is a power of two, pointers wrap on overflow
    assign rd_ptr_p1 = rd_ptr + 1'b1;
    assign wr_ptr_p1 = wr_ptr + 1'b1;

    // a full packet must always fit
    assign write_ready_o = int'(count) <= DEPTH - 2;

    assign read_valid_o[0] = (count > 0);
    assign read_valid_o[1] = (count > 1);
    assign read_data_o[0]  = mem[rd_ptr];
    assign read_data_o[1]  = mem[rd_ptr_p1];

    always_comb begin
        push_num = (write_num_i == 2'd3) ? 2'd2 : write_num_i;
        pop_num  = (read_num_i == 2'd3) ? 2'd2 : read_num_i;
        // never pop more than is held
        if (pop_num > count) begin
            pop_num = count[1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            rd_ptr <= rd_ptr + pop_num;
            wr_ptr <= wr_ptr + push_num;
            count  <= count + push_num - pop_num;
        end
    end

    always_ff @(posedge clk) begin
        if (!flush_i) begin
            if (push_num != 2'd0) begin
                mem[wr_ptr] <= write_data_i[0];
            end
            if (push_num == 2'd2) begin
                mem[wr_ptr_p1] <= write_data_i[1];
            end
        end
    end

endmodule

`default_nettype wire

/* frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module frontend (
    input  wire logic                          clk,
    input  wire logic                          rst_n_i,

    // instruction memory, axi4-lite read
    output logic      [frontend_pkg::XLEN-1:0] araddr_o,
    output logic      [2:0]                    arprot_o,
    output logic                               arvalid_o,
    input  wire logic                          arready_i,
    input  wire logic [frontend_pkg::XLEN-1:0] rdata_i,
    input  wire logic [1:0]                    rresp_i,
    input  wire logic                          rvalid_i,
    output logic                               rready_o,

    // backend control
    input  wire logic                          flush_i,
    input  wire logic [frontend_pkg::XLEN-1:0] redirect_pc_i,
    input  wire logic [1:0]                    issue_num_i,
    input  wire logic                          backend_stall_i,

    // issued instructions
    output logic [1:0]                              inst_valid_o,
    output logic [1:0][frontend_pkg::XLEN-1:0]      inst_pc_o,
    output logic [1:0][frontend_pkg::XLEN-1:0]      inst_word_o,
    output logic [1:0][4:0]                         inst_rj_o,
    output logic [1:0][4:0]                         inst_rk_o,
    output logic [1:0][4:0]                         inst_rd_o
);

    logic [frontend_pkg::XLEN-1:0] fetch_pc;
    logic                          pc_ready;

    logic [frontend_pkg::FETCH_WIDTH-1:0][frontend_pkg::XLEN-1:0] pd_word;
    logic [frontend_pkg::FETCH_WIDTH-1:0][4:0] pd_rj;
    logic [frontend_pkg::FETCH_WIDTH-1:0][4:0] pd_rk;
    logic [frontend_pkg::FETCH_WIDTH-1:0][4:0] pd_rd;

    logic                       write_ready;
    logic [1:0]                 write_num;
    logic [1:0]                 read_num;
    frontend_pkg::fetch_entry_t [1:0] write_data;
    frontend_pkg::fetch_entry_t [1:0] read_data;

    // a stalled backend takes nothing
    assign read_num = backend_stall_i ? 2'd0 : issue_num_i;

    npc u_npc (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .redirect_pc_i (redirect_pc_i),
        .pc_ready_i    (pc_ready),
        .pc_o          (fetch_pc)
    );

    fetch_unit u_fetch (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .pc_i          (fetch_pc),
        .pc_ready_o    (pc_ready),
        .araddr_o      (araddr_o),
        .arprot_o      (arprot_o),
        .arvalid_o     (arvalid_o),
        .arready_i     (arready_i),
        .rdata_i       (rdata_i),
        .rresp_i       (rresp_i),
        .rvalid_i      (rvalid_i),
        .rready_o      (rready_o),
        .pd_word_o     (pd_word),
        .pd_rj_i       (pd_rj),
        .pd_rk_i       (pd_rk),
        .pd_rd_i       (pd_rd),
        .write_ready_i (write_ready),
        .write_num_o   (write_num),
        .write_data_o  (write_data)
    );

    for (genvar k = 0; k < frontend_pkg::FETCH_WIDTH; k++) begin : g_predecode
        inst_predecode u_predecode (
            .word_i (pd_word[k]),
            .rj_o   (pd_rj[k]),
            .rk_o   (pd_rk[k]),
            .rd_o   (pd_rd[k])
        );
    end

    multi_channel_fifo #(
        .T     (frontend_pkg::fetch_entry_t),
        .DEPTH (frontend_pkg::FIFO_DEPTH)
    ) u_inst_fifo (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .write_num_i   (write_num),
        .write_data_i  (write_data),
        .write_ready_o (write_ready),
        .read_num_i    (read_num),
        .read_valid_o  (inst_valid_o),
        .read_data_o   (read_data)
    );

    // unpack the issue lanes
    for (genvar k = 0; k < 2; k++) begin : g_issue
        assign inst_pc_o[k]   = read_data[k].pc;
        assign inst_word_o[k] = read_data[k].word;
        assign inst_rj_o[k]   = read_data[k].rj;
        assign inst_rk_o[k]   = read_data[k].rk;
        assign inst_rd_o[k]   = read_data[k].rd;
    end

endmodule

`default_nettype wire

/* tb_imem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_imem (
    input  wire logic        clk,
    input  wire logic        rst_n_i,

    // read address channel
    input  wire logic [31:0] araddr_i,
    input  wire logic        arvalid_i,
    output logic             arready_o,

    // read data channel
    output logic      [31:0] rdata_o,
    output logic      [1:0]  rresp_o,
    output logic             rvalid_o,
    input  wire logic        rready_i
);

    logic [31:0] rd_addr;
    logic        busy;
    logic [1:0]  ar_wait;
    logic [1:0]  r_wait;

    // same word function as in tb_frontend
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] h;
        h = (addr ^ 32'h5bd1_e995) * 32'h9e37_79b1;
        h = h ^ (h >> 13);
        // opcode walks all 64 values over 64 sequential words
        return {addr[7:2] ^ addr[13:8], h[25:0]};
    endfunction

    assign rresp_o = 2'b00;

    // one read at a time, 0 to 3 wait cycles on each channel
    always @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            arready_o <= 1'b0;
            rvalid_o  <= 1'b0;
            rdata_o   <= '0;
            rd_addr   <= '0;
            busy      <= 1'b0;
            ar_wait   <= '0;
            r_wait    <= '0;
        end else if (!busy) begin
            if (arvalid_i && arready_o) begin
                arready_o <= 1'b0;
                rd_addr   <= araddr_i;
                busy      <= 1'b1;
                r_wait    <= 2'($urandom_range(0, 3));
            end else if (!arready_o) begin
                if (ar_wait == 2'd0) begin
                    arready_o <= 1'b1;
                end else begin
                    ar_wait <= ar_wait - 1'b1;
                end
            end
        end else if (rvalid_o) begin
            if (rready_i) begin
                rvalid_o <= 1'b0;
                busy     <= 1'b0;
                ar_wait  <= 2'($urandom_range(0, 3));
            end
        end else if (r_wait == 2'd0) begin
            rvalid_o <= 1'b1;
            rdata_o  <= mem_word(rd_addr);
        end else begin
            r_wait <= r_wait - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* tb_frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_frontend;

    // worst memory delay costs about 10 cycles per instruction
    localparam int TOTAL_INSTS    = 400;
    localparam int CYCLES_PER_INS = 10;
    localparam int MAX_CYCLES     = 20 * TOTAL_INSTS * CYCLES_PER_INS;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        flush;
    logic [31:0] redirect_pc;
    logic [1:0]  issue_num = 2'd0;
    logic        backend_stall = 1'b0;
    // 0 idle, 1 full width, 2 random
    logic [1:0]  mode = 2'd0;

    logic [31:0] araddr;
    logic [2:0]  arprot;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    logic [1:0]       inst_valid;
    logic [1:0][31:0] inst_pc;
    logic [1:0][31:0] inst_word;
    logic [1:0][4:0]  inst_rj;
    logic [1:0][4:0]  inst_rk;
    logic [1:0][4:0]  inst_rd;

    logic [31:0] exp_pc;
    logic [31:0] ar_addr_q;
    logic        ar_hold;
    int          errors = 0;
    int          issued = 0;
    int          cycles = 0;
    int          class_seen [6];

    always #50 clk = ~clk;

    frontend UUT (
        .clk             (clk),
        .rst_n_i         (rst_n),
        .araddr_o        (araddr),
        .arprot_o        (arprot),
        .arvalid_o       (arvalid),
        .arready_i       (arready),
        .rdata_i         (rdata),
        .rresp_i         (rresp),
        .rvalid_i        (rvalid),
        .rready_o        (rready),
        .flush_i         (flush),
        .redirect_pc_i   (redirect_pc),
        .issue_num_i     (issue_num),
        .backend_stall_i (backend_stall),
        .inst_valid_o    (inst_valid),
        .inst_pc_o       (inst_pc),
        .inst_word_o     (inst_word),
        .inst_rj_o       (inst_rj),
        .inst_rk_o       (inst_rk),
        .inst_rd_o       (inst_rd)
    );

    tb_imem u_imem (
        .clk       (clk),
        .rst_n_i   (rst_n),
        .araddr_i  (araddr),
        .arvalid_i (arvalid),
        .arready_o (arready),
        .rdata_o   (rdata),
        .rresp_o   (rresp),
        .rvalid_o  (rvalid),
        .rready_i  (rready)
    );

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] h;
        h = (addr ^ 32'h5bd1_e995) * 32'h9e37_79b1;
        h = h ^ (h >> 13);
        return {addr[7:2] ^ addr[13:8], h[25:0]};
    endfunction

    // expected word and register indices for one pc
    function automatic void ref_inst(input logic [31:0] pc, output logic [31:0] word,
                                     output logic [4:0] rj, output logic [4:0] rk,
                                     output logic [4:0] rd, output int cls);
        logic [5:0] op;
        word = mem_word(pc);
        op   = word[31:26];
        rj   = 5'd0;
        rk   = 5'd0;
        rd   = 5'd0;
        // class index 0 rw, 1 rrw, 2 i, 3 bl, 4 rr, 5 w
        if (op == 6'd0) begin
            cls = 1;
            rk  = word[14:10];
            rj  = word[9:5];
            rd  = word[4:0];
        end else if (op == 6'd5) begin
            cls = 5;
            rd  = word[4:0];
        end else if (op < 6'd16) begin
            cls = 0;
            rj  = word[9:5];
            rd  = word[4:0];
        end else if (op == 6'd21) begin
            cls = 3;
            rd  = 5'd1;
        end else if (op >= 6'd22 && op <= 6'd27) begin
            cls = 4;
            rk  = word[4:0];
            rj  = word[9:5];
        end else begin
            cls = 2;
        end
    endfunction

    // backend issue controls
    always @(posedge clk) begin
        if (mode == 2'd2) begin
            issue_num     <= 2'($urandom_range(0, 2));
            backend_stall <= ($urandom_range(0, 3) == 0);
        end else begin
            issue_num     <= (mode == 2'd1) ? 2'd2 : 2'd0;
            backend_stall <= 1'b0;
        end
    end

    // compare, outputs sampled mid-cycle
    always @(negedge clk) begin
        int avail;
        int want;
        int popped;
        int e_cls;
        logic [31:0] e_word;
        logic [4:0]  e_rj;
        logic [4:0]  e_rk;
        logic [4:0]  e_rd;
        if (!rst_n) begin
            assert (inst_valid == 2'b00 && !arvalid && !rready) else begin
                errors++;
                $display("FAILED %0t: outputs active during reset", $time);
            end
            exp_pc  = frontend_pkg::RESET_PC;
            ar_hold = 1'b0;
        end else begin
            // AR held until accepted
            if (ar_hold) begin
                assert (arvalid && araddr == ar_addr_q) else begin
                    errors++;
                    $display("FAILED %0t: AR dropped or changed before handshake", $time);
                end
            end
            ar_hold   = arvalid && !arready;
            ar_addr_q = araddr;
            if (arvalid) begin
                assert (arprot[2]) else begin
                    errors++;
                    $display("FAILED %0t: arprot 0x%h is not an instruction access",
                             $time, arprot);
                end
            end
            avail  = inst_valid[1] ? 2 : (inst_valid[0] ? 1 : 0);
            want   = backend_stall ? 0 : int'(issue_num);
            popped = (want < avail) ? want : avail;
            if (flush) begin
                exp_pc = {redirect_pc[31:2], 2'b00};
            end else begin
                // every lane shown as valid must hold the next instruction in order
                for (int k = 0; k < avail; k++) begin
                    assert (inst_pc[k] == exp_pc + 32'(4 * k)) else begin
                        errors++;
                        $display("FAILED %0t: valid lane %0d pc 0x%h expected 0x%h",
                                 $time, k, inst_pc[k], exp_pc + 32'(4 * k));
                    end
                end
                for (int k = 0; k < popped; k++) begin
                    ref_inst(exp_pc, e_word, e_rj, e_rk, e_rd, e_cls);
                    assert (inst_pc[k] == exp_pc) else begin
                        errors++;
                        $display("FAILED %0t: lane %0d pc 0x%h expected 0x%h",
                                 $time, k, inst_pc[k], exp_pc);
                    end
                    assert (inst_word[k] == e_word) else begin
                        errors++;
                        $display("FAILED %0t: pc 0x%h word 0x%h expected 0x%h",
                                 $time, exp_pc, inst_word[k], e_word);
                    end
                    assert ({inst_rj[k], inst_rk[k], inst_rd[k]} == {e_rj, e_rk, e_rd})
                    else begin
                        errors++;
                        $display("FAILED %0t: pc 0x%h rj/rk/rd %0d/%0d/%0d expected %0d/%0d/%0d",
                                 $time, exp_pc, inst_rj[k], inst_rk[k], inst_rd[k],
                                 e_rj, e_rk, e_rd);
                    end
                    class_seen[e_cls]++;
                    issued++;
                    exp_pc = exp_pc + 32'd4;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles with %0d instructions checked", cycles, issued);
            $display("errors: %0d", errors);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic wait_issued(input int n);
        int target;
        target = issued + n;
        while (issued < target) begin
            @(posedge clk);
        end
    endtask

    task automatic pulse_flush(input logic [31:0] target);
        @(posedge clk);
        flush       <= 1'b1;
        redirect_pc <= target;
        @(posedge clk);
        flush       <= 1'b0;
    endtask

    // flush once a read is outstanding on R, or waiting on AR
    task automatic flush_when_busy(input logic [31:0] target, input logic on_data);
        @(negedge clk);
        while (on_data ? !rready : !(arvalid && !arready)) begin
            @(negedge clk);
        end
        pulse_flush(target);
    endtask

    initial begin
        void'($urandom(38376));
        rst_n       = 1'b0;
        flush       = 1'b0;
        redirect_pc = '0;
        for (int c = 0; c < 6; c++) begin
            class_seen[c] = 0;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        mode  <= 2'd1;
        wait_issued(200);
        mode <= 2'd2;
        wait_issued(100);
        // offset 0 and offset 4 targets
        pulse_flush(32'h1c00_4000);
        wait_issued(30);
        pulse_flush(32'h1c00_8006);
        wait_issued(30);
        for (int i = 0; i < 3; i++) begin
            flush_when_busy(32'h1c01_0000 + 32'(i) * 32'h104, 1'b1);
            wait_issued(10);
        end
        flush_when_busy(32'h1c02_0004, 1'b0);
        while (issued < TOTAL_INSTS) begin
            @(posedge clk);
        end
        mode <= 2'd0;
        repeat (4) @(posedge clk);
        for (int c = 0; c < 6; c++) begin
            assert (class_seen[c] > 0) else begin
                errors++;
                $display("register class %0d was never issued", c);
            end
        end
        $display("checked %0d instructions, %0d errors", issued, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
frontend_pkg.sv
npc.sv
inst_predecode.sv
fetch_unit.sv
multi_channel_fifo.sv
frontend.sv
tb_imem.sv
tb_frontend.sv

/* run.sh */
#!/bin/sh
# build and run the frontend testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_frontend -f filelist.f -o sim_frontend
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_frontend)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1
